//--- rtl/uart_pkg.sv
package uart_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // register map, word addresses.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam logic [1:0] addr_txcmd  = 2'd0;
   localparam logic [1:0] addr_status = 2'd1;
   localparam logic [1:0] addr_rxdata = 2'd2;

   // bit positions in the low byte of the status word.
   localparam int st_tx_busy    = 0;
   localparam int st_rx_valid   = 1;
   localparam int st_parity_err = 2;
   localparam int st_overrun    = 3;

   // start, 8 data, odd parity, stop.
   localparam int frame_bits = 11;

   // the command is written as one halfword and sent as two bytes, low byte first.
   typedef union packed {
      logic [15:0] raw;
      struct packed {
         logic [7:0] hi;
         logic [7:0] lo;
      } bytes;
   } cmd_word_u;

endpackage

//--- rtl/uart_regs.sv
`timescale 1ns/1ps

module uart_regs (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                s_cyc,
   input  logic                s_stb,
   input  logic                s_we,
   input  logic [1:0]          s_adr,
   input  logic [15:0]         s_dat_w,
   output logic [15:0]         s_dat_r,
   output logic                s_ack,
   output logic                tx_load,
   output uart_pkg::cmd_word_u cmd,
   input  logic                tx_busy,
   input  logic                rx_valid,
   input  logic [7:0]          rx_data,
   input  logic                rx_perr
);

   logic       req;
   logic       wr_tx;
   logic       take;
   logic       rd_rx;
   logic       flag_valid;
   logic       flag_perr;
   logic       flag_ovr;
   logic [7:0] rx_byte;
   logic [7:0] status;

   assign req   = s_cyc && s_stb && !s_ack;
   assign wr_tx = s_we && (s_adr == uart_pkg::addr_txcmd);
   // a command write stalls while a command is on the line.
   assign take  = req && !(wr_tx && tx_busy);
   assign rd_rx = take && !s_we && (s_adr == uart_pkg::addr_rxdata);

   always_comb begin
      status = '0;
      status[uart_pkg::st_tx_busy]    = tx_busy;
      status[uart_pkg::st_rx_valid]   = flag_valid;
      status[uart_pkg::st_parity_err] = flag_perr;
      status[uart_pkg::st_overrun]    = flag_ovr;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s_ack      <= 1'b0;
         tx_load    <= 1'b0;
         flag_valid <= 1'b0;
         flag_perr  <= 1'b0;
         flag_ovr   <= 1'b0;
      end else begin
         s_ack   <= take;
         tx_load <= take && wr_tx;
         if (rx_valid) begin
            // a byte still unread when the next one lands is an overrun.
            flag_valid <= 1'b1;
            flag_perr  <= rx_perr || (flag_perr && !rd_rx);
            flag_ovr   <= (flag_valid || flag_ovr) && !rd_rx;
         end else if (rd_rx) begin
            flag_valid <= 1'b0;
            flag_perr  <= 1'b0;
            flag_ovr   <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take && wr_tx) cmd.raw <= s_dat_w;
      if (rx_valid) rx_byte <= rx_data;
      if (take) begin
         case (s_adr)
            uart_pkg::addr_txcmd:  s_dat_r <= cmd.raw;
            uart_pkg::addr_status: s_dat_r <= {8'h00, status};
            uart_pkg::addr_rxdata: s_dat_r <= {8'h00, rx_byte};
            default:               s_dat_r <= '0;
         endcase
      end
   end

   a_ack_with_stb: assert property (@(posedge clk) disable iff (!rst_n)
      s_ack |-> s_stb);

endmodule

//--- rtl/uart_rx.sv
`timescale 1ns/1ps

module uart_rx #(
   parameter int clks_per_bit = 8
) (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       rx,
   output logic       rx_valid,
   output logic [7:0] rx_data,
   output logic       rx_perr
);

   localparam int cw = $clog2(clks_per_bit);

   localparam logic [1:0] idle_st  = 2'd0;
   localparam logic [1:0] start_st = 2'd1;
   localparam logic [1:0] data_st  = 2'd2;
   localparam logic [1:0] stop_st  = 2'd3;

   logic          rx_s1;
   logic          rx_s2;
   logic          rx_prev;
   logic [1:0]    state;
   logic [cw-1:0] clk_cnt;
   logic [3:0]    bit_idx;
   logic [8:0]    shreg;
   logic          bit_end;
   logic          half_bit;
   logic          done;

   assign bit_end  = clk_cnt == cw'(clks_per_bit - 1);
   assign half_bit = clk_cnt == cw'(clks_per_bit / 2 - 1);
   assign done     = (state == stop_st) && bit_end;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_s1   <= 1'b1;
         rx_s2   <= 1'b1;
         rx_prev <= 1'b1;
      end else begin
         rx_s1   <= rx;
         rx_s2   <= rx_s1;
         rx_prev <= rx_s2;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // frame FSM, sampling in mid-bit.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= idle_st;
         clk_cnt  <= '0;
         bit_idx  <= '0;
         rx_valid <= 1'b0;
      end else begin
         // the pulse lands in the middle of the stop bit.
         rx_valid <= done;
         case (state)
            idle_st: begin
               if (rx_prev && !rx_s2) begin
                  state   <= start_st;
                  clk_cnt <= '0;
               end
            end
            start_st: begin
               if (half_bit) begin
                  // a start bit that is high again by now was only a glitch.
                  state   <= rx_s2 ? idle_st : data_st;
                  clk_cnt <= '0;
                  bit_idx <= '0;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            data_st: begin
               if (bit_end) begin
                  clk_cnt <= '0;
                  bit_idx <= bit_idx + 4'd1;
                  if (bit_idx == 4'd8) state <= stop_st;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            default: begin
               if (bit_end) state <= idle_st;
               else clk_cnt <= clk_cnt + 1'b1;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == data_st && bit_end) shreg <= {rx_s2, shreg[8:1]};
      if (done) begin
         rx_data <= shreg[7:0];
         // good odd parity leaves the xor of data and parity at one.
         rx_perr <= ~^shreg;
      end
   end

   a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
      rx_valid |=> !rx_valid);

endmodule

//--- rtl/uart_top.sv
`timescale 1ns/1ps

module uart_top #(
   parameter int clks_per_bit = 8
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        m0_cyc,
   input  logic        m0_stb,
   input  logic        m0_we,
   input  logic [1:0]  m0_adr,
   input  logic [15:0] m0_dat_w,
   output logic [15:0] m0_dat_r,
   output logic        m0_ack,
   input  logic        m1_cyc,
   input  logic        m1_stb,
   input  logic        m1_we,
   input  logic [1:0]  m1_adr,
   input  logic [15:0] m1_dat_w,
   output logic [15:0] m1_dat_r,
   output logic        m1_ack,
   output logic        tx,
   input  logic        rx
);

   logic                s_cyc;
   logic                s_stb;
   logic                s_we;
   logic [1:0]          s_adr;
   logic [15:0]         s_dat_w;
   logic [15:0]         s_dat_r;
   logic                s_ack;
   logic                tx_load;
   logic                tx_busy;
   uart_pkg::cmd_word_u cmd;
   logic                rx_valid;
   logic [7:0]          rx_data;
   logic                rx_perr;

   wb_arbiter wb_arbiter_i (
      .clk, .rst_n,
      .m0_cyc, .m0_stb, .m0_we, .m0_adr, .m0_dat_w, .m0_dat_r, .m0_ack,
      .m1_cyc, .m1_stb, .m1_we, .m1_adr, .m1_dat_w, .m1_dat_r, .m1_ack,
      .s_cyc, .s_stb, .s_we, .s_adr, .s_dat_w, .s_dat_r, .s_ack
   );

   uart_regs uart_regs_i (
      .clk, .rst_n,
      .s_cyc, .s_stb, .s_we, .s_adr, .s_dat_w, .s_dat_r, .s_ack,
      .tx_load, .cmd, .tx_busy,
      .rx_valid, .rx_data, .rx_perr
   );

   uart_tx #(.clks_per_bit(clks_per_bit)) uart_tx_i (
      .clk, .rst_n, .tx_load, .cmd, .tx, .tx_busy
   );

   uart_rx #(.clks_per_bit(clks_per_bit)) uart_rx_i (
      .clk, .rst_n, .rx, .rx_valid, .rx_data, .rx_perr
   );

endmodule

//--- rtl/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
   parameter int clks_per_bit = 8
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                tx_load,
   input  uart_pkg::cmd_word_u cmd,
   output logic                tx,
   output logic                tx_busy
);

   localparam int total_bits = 2 * uart_pkg::frame_bits;
   localparam int cw         = $clog2(clks_per_bit);
   localparam int bw         = $clog2(total_bits);

   logic [cw-1:0]         clk_cnt;
   logic [bw-1:0]         bit_cnt;
   logic [total_bits-2:0] shreg;
   logic                  par_lo;
   logic                  par_hi;

   // odd parity, so data plus parity always holds an odd number of ones.
   assign par_lo = ~^cmd.bytes.lo;
   assign par_hi = ~^cmd.bytes.hi;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tx      <= 1'b1;
         tx_busy <= 1'b0;
         clk_cnt <= '0;
         bit_cnt <= '0;
         shreg   <= '1;
      end else if (tx_load && !tx_busy) begin
         // the start bit of the low frame goes out at once, the rest waits in the shifter.
         tx      <= 1'b0;
         tx_busy <= 1'b1;
         clk_cnt <= '0;
         bit_cnt <= '0;
         shreg   <= {1'b1, par_hi, cmd.bytes.hi, 1'b0, 1'b1, par_lo, cmd.bytes.lo};
      end else if (tx_busy) begin
         if (clk_cnt == cw'(clks_per_bit - 1)) begin
            clk_cnt <= '0;
            if (bit_cnt == bw'(total_bits - 1)) begin
               // end of the second stop bit.
               tx      <= 1'b1;
               tx_busy <= 1'b0;
            end else begin
               tx      <= shreg[0];
               shreg   <= {1'b1, shreg[total_bits-2:1]};
               bit_cnt <= bit_cnt + 1'b1;
            end
         end else begin
            clk_cnt <= clk_cnt + 1'b1;
         end
      end
   end

   // the register block must hold a command back until the line is free.
   a_no_load_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(tx_load) |-> !tx_busy);

endmodule

//--- rtl/wb_arbiter.sv
`timescale 1ns/1ps

module wb_arbiter (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        m0_cyc,
   input  logic        m0_stb,
   input  logic        m0_we,
   input  logic [1:0]  m0_adr,
   input  logic [15:0] m0_dat_w,
   output logic [15:0] m0_dat_r,
   output logic        m0_ack,
   input  logic        m1_cyc,
   input  logic        m1_stb,
   input  logic        m1_we,
   input  logic [1:0]  m1_adr,
   input  logic [15:0] m1_dat_w,
   output logic [15:0] m1_dat_r,
   output logic        m1_ack,
   output logic        s_cyc,
   output logic        s_stb,
   output logic        s_we,
   output logic [1:0]  s_adr,
   output logic [15:0] s_dat_w,
   input  logic [15:0] s_dat_r,
   input  logic        s_ack
);

   logic gnt;
   logic sel;
   logic last;
   logic pick;

   // a contested request goes to the master that lost the last contest.
   assign pick = (m0_cyc && m1_cyc) ? ~last : m1_cyc;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gnt  <= 1'b0;
         sel  <= 1'b0;
         last <= 1'b1;
      end else if (!gnt) begin
         if (m0_cyc || m1_cyc) begin
            gnt <= 1'b1;
            sel <= pick;
            if (m0_cyc && m1_cyc) last <= pick;
         end
      end else if (!(sel ? m1_cyc : m0_cyc)) begin
         gnt <= 1'b0;
      end
   end

   assign s_cyc   = gnt && (sel ? m1_cyc : m0_cyc);
   assign s_stb   = gnt && (sel ? m1_stb : m0_stb);
   assign s_we    = sel ? m1_we : m0_we;
   assign s_adr   = sel ? m1_adr : m0_adr;
   assign s_dat_w = sel ? m1_dat_w : m0_dat_w;

   // the master that is not granted sees no ack and waits.
   assign m0_ack   = gnt && !sel && s_ack;
   assign m1_ack   = gnt && sel && s_ack;
   assign m0_dat_r = (gnt && !sel) ? s_dat_r : '0;
   assign m1_dat_r = (gnt && sel) ? s_dat_r : '0;

   a_one_ack: assert property (@(posedge clk) disable iff (!rst_n)
      !(m0_ack && m1_ack));

endmodule

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_uart -o sim_tb_uart
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_tb_uart)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTBENCH PASSED"; then
   exit 0
fi
exit 1

//--- tb.f
rtl/uart_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/wb_arbiter.sv
rtl/uart_regs.sv
rtl/uart_top.sv
tests/tb_uart.sv

//--- tests/tb_uart.sv
`timescale 1ns/1ps

module tb_uart;

   localparam int clks_per_bit = 8;
   localparam int clk_period   = 8;
   // the tests send eleven frames of 88 cycles, so this is a wide margin.
   localparam int max_cycles   = 20000;

   logic        clk;
   logic        rst_n;
   logic [1:0]  m_cyc;
   logic [1:0]  m_stb;
   logic [1:0]  m_we;
   logic [1:0]  m_adr [2];
   logic [15:0] m_dat_w [2];
   logic [15:0] m_dat_r [2];
   logic [1:0]  m_ack;
   logic        tx;
   logic        rx;
   logic        line_rx;
   logic        loopback;

   int          err_cnt   = 0;
   int          test_cnt  = 0;
   int          fail_cnt  = 0;
   int          cycle_cnt = 0;
   time         ack_time [2];
   int          ack_lat [2];
   logic [31:0] lcg_state = 32'h79b2;

   // the receiver listens either to the transmitter or to the testbench line.
   assign rx = loopback ? tx : line_rx;

   uart_top #(.clks_per_bit(clks_per_bit)) uart_top_i (
      .clk, .rst_n,
      .m0_cyc(m_cyc[0]), .m0_stb(m_stb[0]), .m0_we(m_we[0]), .m0_adr(m_adr[0]),
      .m0_dat_w(m_dat_w[0]), .m0_dat_r(m_dat_r[0]), .m0_ack(m_ack[0]),
      .m1_cyc(m_cyc[1]), .m1_stb(m_stb[1]), .m1_we(m_we[1]), .m1_adr(m_adr[1]),
      .m1_dat_w(m_dat_w[1]), .m1_dat_r(m_dat_r[1]), .m1_ack(m_ack[1]),
      .tx, .rx
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= max_cycles) begin
         $display("the run timed out after %0d cycles", cycle_cnt);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   always @(negedge clk) begin
      if (rst_n && (m_ack & ~m_stb) != 2'b00) begin
         $display("[FAIL] %0t ns: ack reached a master without stb", $time);
         err_cnt++;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // data and expected values.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic uart_pkg::cmd_word_u rand_cmd();
      logic [31:0]         r;
      uart_pkg::cmd_word_u c;
      r = lcg_next();
      c.raw = r[23:8];
      return c;
   endfunction

   function automatic logic [7:0] rand_byte();
      logic [31:0] r;
      r = lcg_next();
      return r[15:8];
   endfunction

   // data and parity together hold an odd number of ones.
   function automatic logic odd_parity(input logic [7:0] b);
      return ($countones(b) % 2) == 0;
   endfunction

   function automatic logic [7:0] status_bits(input logic valid, input logic perr,
                                              input logic ovr);
      logic [7:0] s;
      s = 8'h00;
      s[uart_pkg::st_rx_valid]   = valid;
      s[uart_pkg::st_parity_err] = perr;
      s[uart_pkg::st_overrun]    = ovr;
      return s;
   endfunction

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s: got %b, expected %b", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s: got %02h, expected %02h", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_status(input logic [7:0] got, input logic [7:0] exp, input string what);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s: got %08b, expected %08b", $time, what, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_cmd(input uart_pkg::cmd_word_u got, input uart_pkg::cmd_word_u exp,
                            input string what);
      if (got !== exp) begin
         $display("[FAIL] %0t ns: %s: got lo %02h hi %02h, expected lo %02h hi %02h",
                  $time, what, got.bytes.lo, got.bytes.hi, exp.bytes.lo, exp.bytes.hi);
         err_cnt++;
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // bus and line tasks.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic bus_access(input int m, input logic we, input logic [1:0] adr,
                             input logic [15:0] wdata, output logic [15:0] rdata);
      time t_req;
      @(posedge clk);
      m_cyc[m]   <= 1'b1;
      m_stb[m]   <= 1'b1;
      m_we[m]    <= we;
      m_adr[m]   <= adr;
      m_dat_w[m] <= wdata;
      t_req = $time;
      do begin
         @(negedge clk);
      end while (!m_ack[m]);
      rdata = m_dat_r[m];
      ack_time[m] = $time;
      ack_lat[m] = int'(($time - t_req - clk_period / 2) / clk_period);
      @(posedge clk);
      m_cyc[m] <= 1'b0;
      m_stb[m] <= 1'b0;
   endtask

   task automatic wb_write(input int m, input logic [1:0] adr, input logic [15:0] data);
      logic [15:0] unused_rd;
      bus_access(m, 1'b1, adr, data, unused_rd);
   endtask

   task automatic wb_read(input int m, input logic [1:0] adr, output logic [15:0] data);
      bus_access(m, 1'b0, adr, 16'h0000, data);
   endtask

   task automatic wait_status_flag(input int pos, output logic [7:0] st);
      logic [15:0] rd;
      int          n;
      n = 0;
      do begin
         wb_read(0, uart_pkg::addr_status, rd);
         n++;
      end while (!rd[pos] && n < 200);
      st = rd[7:0];
      if (!rd[pos]) begin
         $display("status bit %0d did not come up after %0d reads", pos, n);
         err_cnt++;
      end
   endtask

   task automatic send_frame(input logic [7:0] b, input logic bad_parity);
      logic [10:0] f;
      f = {1'b1, odd_parity(b) ^ bad_parity, b, 1'b0};
      for (int i = 0; i < uart_pkg::frame_bits; i++) begin
         @(posedge clk);
         line_rx <= f[i];
         repeat (clks_per_bit - 1) @(posedge clk);
      end
   endtask

   // bits are sampled half a bit period after the start edge, then once per bit.
   task automatic sample_frame(output logic [10:0] bits);
      do begin
         @(negedge clk);
      end while (tx !== 1'b0);
      repeat (clks_per_bit / 2) @(negedge clk);
      for (int i = 0; i < uart_pkg::frame_bits; i++) begin
         bits[i] = tx;
         if (i < uart_pkg::frame_bits - 1) repeat (clks_per_bit) @(negedge clk);
      end
   endtask

   task automatic check_framing(input logic [10:0] f, input logic [7:0] b, input string what);
      check_bit(f[0], 1'b0, {what, " start bit"});
      check_bit(f[9], odd_parity(b), {what, " parity bit"});
      check_bit(f[10], 1'b1, {what, " stop bit"});
   endtask

   task automatic expect_cmd(input uart_pkg::cmd_word_u exp, input string what);
      logic [10:0]         f_lo;
      logic [10:0]         f_hi;
      uart_pkg::cmd_word_u got;
      sample_frame(f_lo);
      sample_frame(f_hi);
      got.bytes.lo = f_lo[8:1];
      got.bytes.hi = f_hi[8:1];
      check_cmd(got, exp, what);
      check_framing(f_lo, exp.bytes.lo, "low frame");
      check_framing(f_hi, exp.bytes.hi, "high frame");
   endtask

   task automatic end_test(input string name, input int errs_before);
      test_cnt++;
      if (err_cnt == errs_before) begin
         $display("%s: ok", name);
      end else begin
         fail_cnt++;
         $display("%s: %0d failed checks", name, err_cnt - errs_before);
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // tests.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic test_after_reset();
      logic [15:0] rd;
      int          e;
      e = err_cnt;
      check_bit(tx, 1'b1, "tx idle level");
      repeat (4) begin
         @(negedge clk);
         check_bit(|m_ack, 1'b0, "ack while idle");
      end
      wb_read(0, uart_pkg::addr_status, rd);
      check_status(rd[7:0], 8'h00, "status after reset");
      check_byte(8'(ack_lat[0]), 8'd2, "status read latency in cycles");
      end_test("after reset", e);
   endtask

   task automatic test_frame_format();
      uart_pkg::cmd_word_u c;
      logic [15:0]         rd;
      int                  e;
      e = err_cnt;
      c = rand_cmd();
      fork
         begin
            wb_write(0, uart_pkg::addr_txcmd, c.raw);
            wb_read(0, uart_pkg::addr_status, rd);
            check_bit(rd[uart_pkg::st_tx_busy], 1'b1, "tx_busy during frames");
         end
         expect_cmd(c, "command on tx");
      join
      // tx_busy drops at the end of the second stop bit.
      repeat (clks_per_bit) @(posedge clk);
      wb_read(0, uart_pkg::addr_status, rd);
      check_status(rd[7:0], 8'h00, "status after frames");
      end_test("frame format", e);
   endtask

   task automatic test_loopback();
      uart_pkg::cmd_word_u c;
      logic [15:0]         rd;
      logic [7:0]          st;
      int                  e;
      e = err_cnt;
      @(posedge clk);
      loopback <= 1'b1;
      c = rand_cmd();
      wb_write(0, uart_pkg::addr_txcmd, c.raw);
      for (int k = 0; k < 2; k++) begin
         wait_status_flag(uart_pkg::st_rx_valid, st);
         check_status(st & ~8'(1 << uart_pkg::st_tx_busy), status_bits(1'b1, 1'b0, 1'b0),
                      "status with a byte held");
         wb_read(0, uart_pkg::addr_rxdata, rd);
         check_byte(rd[7:0], (k == 0) ? c.bytes.lo : c.bytes.hi, "looped back byte");
      end
      repeat (2 * clks_per_bit) @(posedge clk);
      loopback <= 1'b0;
      end_test("loopback receive", e);
   endtask

   task automatic test_parity_overrun();
      logic [15:0] rd;
      logic [7:0]  st;
      logic [7:0]  b0;
      logic [7:0]  b1;
      logic [7:0]  b2;
      int          e;
      e = err_cnt;
      b0 = rand_byte();
      b1 = rand_byte();
      b2 = rand_byte();
      send_frame(b0, 1'b1);
      wait_status_flag(uart_pkg::st_rx_valid, st);
      check_status(st, status_bits(1'b1, 1'b1, 1'b0), "status after bad parity");
      wb_read(0, uart_pkg::addr_rxdata, rd);
      check_byte(rd[7:0], b0, "byte with bad parity");
      wb_read(0, uart_pkg::addr_status, rd);
      check_status(rd[7:0], 8'h00, "status after rxdata read");
      send_frame(b1, 1'b0);
      send_frame(b2, 1'b0);
      wait_status_flag(uart_pkg::st_overrun, st);
      check_status(st, status_bits(1'b1, 1'b0, 1'b1), "status after overrun");
      wb_read(0, uart_pkg::addr_rxdata, rd);
      check_byte(rd[7:0], b2, "byte held after overrun");
      wb_read(0, uart_pkg::addr_status, rd);
      check_status(rd[7:0], 8'h00, "status after overrun cleared");
      end_test("parity error and overrun", e);
   endtask

   task automatic test_arbitration();
      logic [15:0] rd0;
      logic [15:0] rd1;
      int          e;
      e = err_cnt;
      for (int r = 0; r < 2; r++) begin
         fork
            wb_read(0, uart_pkg::addr_status, rd0);
            wb_read(1, uart_pkg::addr_status, rd1);
         join
         check_status(rd0[7:0], 8'h00, "status seen by m0");
         check_status(rd1[7:0], 8'h00, "status seen by m1");
         // the first contest goes to m0, the next one to m1.
         check_bit(ack_time[1] < ack_time[0], r == 1, "m1 acked before m0");
      end
      end_test("arbitration", e);
   endtask

   task automatic test_back_pressure();
      uart_pkg::cmd_word_u c0;
      uart_pkg::cmd_word_u c1;
      time                 t_ack;
      time                 t_end;
      int                  e;
      e = err_cnt;
      c0 = rand_cmd();
      c1 = rand_cmd();
      fork
         begin
            wb_write(0, uart_pkg::addr_txcmd, c0.raw);
            wb_write(0, uart_pkg::addr_txcmd, c1.raw);
            t_ack = ack_time[0];
         end
         begin
            expect_cmd(c0, "first command");
            t_end = $time;
            expect_cmd(c1, "second command");
         end
      join
      check_bit(t_ack > t_end, 1'b1, "second write held until the line is free");
      end_test("back-pressure", e);
   endtask

   initial begin
      rst_n      = 1'b0;
      m_cyc      = 2'b00;
      m_stb      = 2'b00;
      m_we       = 2'b00;
      m_adr[0]   = 2'd0;
      m_adr[1]   = 2'd0;
      m_dat_w[0] = 16'h0000;
      m_dat_w[1] = 16'h0000;
      line_rx    = 1'b1;
      loopback   = 1'b0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      test_after_reset();
      test_frame_format();
      test_loopback();
      test_parity_overrun();
      test_arbitration();
      test_back_pressure();
      $display("tests run %0d, tests failed %0d, failed checks %0d",
               test_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule
